// ==== files.f ====
+incdir+.
core_pkg.sv
core_stage_reg.sv
core_reg_file.sv
core_alu.sv
core_decoder.sv
core_hazard_ctrl.sv
core_top.sv
core_tb_mem.sv
core_tb.sv

// ==== core_tb.sv ====
// core testbench
// runs one program twice through the pipeline, first with both ports always
// ready and then with random not-ready gaps. an in-order model of the ISA
// gives the expected retire sequence, checked at every wb_valid

`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module core_tb;

localparam int prog_len = 28;
localparam int cycle_ns = 100;
localparam logic [31:0] nop = 32'h0000_0013;

logic clk;
logic rst_n;
logic gaps_on;
logic [`CORE_XLEN-1:0] imem_addr;
logic [`CORE_XLEN-1:0] imem_data;
logic imem_valid;
logic [`CORE_XLEN-1:0] dmem_addr;
logic [`CORE_XLEN-1:0] dmem_wdata;
logic dmem_we;
logic dmem_re;
logic [`CORE_XLEN-1:0] dmem_rdata;
logic dmem_ready;
logic wb_valid;
logic wb_we;
logic [`CORE_REG_W-1:0] wb_rd;
logic [`CORE_XLEN-1:0] wb_data;

logic [31:0] prog [0:prog_len-1];
logic [31:0] ref_ram [0:63];
logic [31:0] ref_regs [0:31];
logic exp_we [$];
logic [4:0] exp_rd [$];
logic [31:0] exp_data [$];
logic [31:0] exp_pc [$];
int exp_idx;
int retired;
int err_value;
int err_other;
logic checking;
logic in_reset;
string run_name;

core_top u_dut (
	.clk(clk), .rst_n(rst_n),
	.imem_addr(imem_addr), .imem_data(imem_data), .imem_valid(imem_valid),
	.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
	.dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready),
	.wb_valid(wb_valid), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
);

core_tb_mem u_mem (
	.clk(clk), .gaps_on(gaps_on),
	.imem_addr(imem_addr), .imem_data(imem_data), .imem_valid(imem_valid),
	.dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
	.dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .dmem_ready(dmem_ready)
);

initial begin
	clk = 1'b0;
end

always #50 clk = ~clk;

// ----------------------------------------------------------------------
// instruction encoders
// ----------------------------------------------------------------------
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [4:0] rd);
	return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// initial RAM word, a different value for every word address
function automatic logic [31:0] fill_word(input int idx);
	return 32'h5a00_0000 ^ (idx * 32'h0001_0203) ^ (idx << 2);
endfunction

function automatic string region_name(input logic [31:0] pc);
	if (pc < 32'd24) return "alu_chain";
	if (pc < 32'd56) return "load_store";
	if (pc < 32'd96) return "branch_jump";
	return "loop";
endfunction

task automatic build_program();
	// dependent ALU chain, x0 as destination and source
	prog[0] = enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'h13);
	prog[1] = enc_i(12'd7, 5'd1, 3'b000, 5'd2, 7'h13);
	prog[2] = enc_r(7'h00, 5'd2, 5'd1, 5'd3);
	prog[3] = enc_r(7'h20, 5'd1, 5'd3, 5'd4);
	prog[4] = enc_i(12'd9, 5'd4, 3'b000, 5'd0, 7'h13);
	prog[5] = enc_r(7'h00, 5'd4, 5'd0, 5'd5);
	// load-use, store data forwarding, read back
	prog[6] = enc_i(12'd8, 5'd0, 3'b010, 5'd6, 7'h03);
	prog[7] = enc_r(7'h00, 5'd1, 5'd6, 5'd7);
	prog[8] = enc_i(12'd3, 5'd7, 3'b000, 5'd8, 7'h13);
	prog[9] = enc_s(12'd12, 5'd8, 5'd0);
	prog[10] = enc_i(12'd12, 5'd0, 3'b010, 5'd9, 7'h03);
	prog[11] = enc_i(12'd16, 5'd0, 3'b010, 5'd10, 7'h03);
	prog[12] = enc_s(12'd20, 5'd10, 5'd0);
	prog[13] = enc_i(12'd20, 5'd0, 3'b010, 5'd11, 7'h03);
	// taken beq, untaken bne, jal with link
	prog[14] = enc_b(13'd12, 5'd1, 5'd1, 3'b000);
	prog[15] = enc_i(12'd1, 5'd0, 3'b000, 5'd12, 7'h13);
	prog[16] = enc_i(12'd2, 5'd0, 3'b000, 5'd12, 7'h13);
	prog[17] = enc_b(13'd8, 5'd1, 5'd1, 3'b001);
	prog[18] = enc_i(12'd11, 5'd0, 3'b000, 5'd13, 7'h13);
	prog[19] = enc_j(21'd12, 5'd14);
	prog[20] = enc_i(12'd1, 5'd0, 3'b000, 5'd15, 7'h13);
	prog[21] = enc_i(12'd2, 5'd0, 3'b000, 5'd15, 7'h13);
	prog[22] = enc_r(7'h00, 5'd13, 5'd14, 5'd16);
	prog[23] = enc_r(7'h20, 5'd5, 5'd16, 5'd17);
	// three-pass countdown loop
	prog[24] = enc_i(12'd3, 5'd0, 3'b000, 5'd18, 7'h13);
	prog[25] = enc_i(12'hfff, 5'd18, 3'b000, 5'd18, 7'h13);
	prog[26] = enc_b(13'h1ffc, 5'd0, 5'd18, 3'b001);
	prog[27] = enc_r(7'h00, 5'd16, 5'd18, 5'd19);
endtask

task automatic load_memories();
	for (int i = 0; i < 64; i++) begin
		u_mem.rom[i] = (i < prog_len) ? prog[i] : nop;
		u_mem.ram[i] = fill_word(i);
		ref_ram[i] = fill_word(i);
	end
endtask

// ----------------------------------------------------------------------
// in-order ISA model, one entry per retired instruction
// ----------------------------------------------------------------------
task automatic build_expected();
	logic [31:0] pc;
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] val;
	logic [31:0] next;
	logic [31:0] addr;
	logic we;
	int steps;
	exp_we.delete();
	exp_rd.delete();
	exp_data.delete();
	exp_pc.delete();
	exp_idx = 0;
	for (int r = 0; r < 32; r++) begin
		ref_regs[r] = '0;
	end
	pc = '0;
	steps = 0;
	while (pc[31:2] < prog_len && steps < 200) begin
		ins = prog[pc[31:2]];
		a = ref_regs[ins[19:15]];
		b = ref_regs[ins[24:20]];
		next = pc + 32'd4;
		we = 1'b0;
		val = '0;
		case (ins[6:0])
			7'h33: begin
				we = 1'b1;
				val = ins[30] ? a - b : a + b;
			end
			7'h13: begin
				we = 1'b1;
				val = a + {{20{ins[31]}}, ins[31:20]};
			end
			7'h03: begin
				we = 1'b1;
				addr = a + {{20{ins[31]}}, ins[31:20]};
				val = ref_ram[addr[7:2]];
			end
			7'h23: begin
				addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				ref_ram[addr[7:2]] = b;
			end
			7'h63: begin
				if ((a == b) != ins[12]) begin
					next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			end
			7'h6f: begin
				we = 1'b1;
				val = pc + 32'd4;
				next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			default: begin
			end
		endcase
		if (we && ins[11:7] != 5'd0) begin
			ref_regs[ins[11:7]] = val;
		end
		exp_we.push_back(we);
		exp_rd.push_back(ins[11:7]);
		exp_data.push_back(val);
		exp_pc.push_back(pc);
		pc = next;
		steps++;
	end
endtask

// ----------------------------------------------------------------------
// checks, sampled mid-cycle
// ----------------------------------------------------------------------
task automatic check_retire();
	string name;
	if (exp_idx >= exp_we.size()) begin
		err_other++;
		$display("%s: rd %0d retired after the end of the program", run_name, wb_rd);
	end
	else begin
		name = {run_name, "/", region_name(exp_pc[exp_idx])};
		assert (wb_we == exp_we[exp_idx]) else begin
			err_value++;
			$display("error %s pc %0h wb_we: expected %0b, actual %0b", name,
				exp_pc[exp_idx], exp_we[exp_idx], wb_we);
		end
		if (exp_we[exp_idx] && exp_rd[exp_idx] != 5'd0) begin
			assert (wb_rd == exp_rd[exp_idx]) else begin
				err_value++;
				$display("error %s pc %0h wb_rd: expected %0d, actual %0d", name,
					exp_pc[exp_idx], exp_rd[exp_idx], wb_rd);
			end
			assert (wb_data == exp_data[exp_idx]) else begin
				err_value++;
				$display("error %s pc %0h wb_data: expected %h, actual %h", name,
					exp_pc[exp_idx], exp_data[exp_idx], wb_data);
			end
		end
		exp_idx++;
		retired++;
	end
endtask

always @(negedge clk) begin
	if (in_reset) begin
		assert (!wb_valid && !dmem_we) else begin
			err_other++;
			$display("%s: the core retired or stored while in reset", run_name);
		end
	end
	if (checking && wb_valid) begin
		check_retire();
	end
end

task automatic run_program(input string name, input logic gaps);
	run_name = name;
	rst_n = 1'b0;
	gaps_on = gaps;
	checking = 1'b0;
	load_memories();
	build_expected();
	@(posedge clk);
	#10;
	in_reset = 1'b1;
	repeat (7) @(posedge clk);
	#10;
	rst_n = 1'b1;
	checking = 1'b1;
	@(posedge clk);
	#10;
	in_reset = 1'b0;
	while (exp_idx < exp_we.size()) begin
		@(posedge clk);
	end
	#10;
	checking = 1'b0;
endtask

task automatic print_counts();
	$display("summary: %0d value errors, %0d other errors, %0d instructions retired",
		err_value, err_other, retired);
endtask

// watchdog, 40 cycles per instruction and run plus the resets
initial begin
	#(cycle_ns * (2 * 10 + 2 * 40 * prog_len));
	$display("timeout: run %s retired %0d of %0d expected instructions",
		run_name, exp_idx, exp_we.size());
	print_counts();
	$display("FAIL: see errors above");
	$finish;
end

initial begin
	rst_n = 1'b0;
	gaps_on = 1'b0;
	checking = 1'b0;
	in_reset = 1'b0;
	exp_idx = 0;
	retired = 0;
	err_value = 0;
	err_other = 0;
	run_name = "init";
	build_program();
	run_program("steady", 1'b0);
	run_program("backpressure", 1'b1);
	print_counts();
	if (err_value + err_other == 0) begin
		$display("PASS: all tests");
	end
	else begin
		$display("FAIL: see errors above");
	end
	$finish;
end

endmodule

`default_nettype wire

// ==== core_tb_mem.sv ====
// core testbench memory
// program ROM and 64-word data RAM answering the fetch and data ports.
// imem_valid and dmem_ready drop on cycles picked by an xorshift sequence

`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module core_tb_mem (
	input wire clk,
	input wire gaps_on,
	input wire [`CORE_XLEN-1:0] imem_addr,
	output logic [`CORE_XLEN-1:0] imem_data,
	output logic imem_valid,
	input wire [`CORE_XLEN-1:0] dmem_addr,
	input wire [`CORE_XLEN-1:0] dmem_wdata,
	input wire dmem_we,
	input wire dmem_re,
	output logic [`CORE_XLEN-1:0] dmem_rdata,
	output logic dmem_ready
);

// both arrays are loaded by the testbench top
logic [`CORE_XLEN-1:0] rom [0:63];
logic [`CORE_XLEN-1:0] ram [0:63];
logic [31:0] rnd_state;

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

initial begin
	imem_data = '0;
	imem_valid = 1'b1;
	dmem_rdata = '0;
	dmem_ready = 1'b1;
	rnd_state = 32'hadde_ee3d;
end

// ----------------------------------------------------------------------
// responses driven just after the rising edge
// ----------------------------------------------------------------------
always @(posedge clk) begin
	#10;
	rnd_state = xorshift(rnd_state);
	// roughly one cycle in four not ready on each port
	imem_valid = !gaps_on || (rnd_state[1:0] != 2'b00);
	dmem_ready = !gaps_on || (rnd_state[9:8] != 2'b00);
	imem_data = rom[imem_addr[7:2]];
	// read data only for a read request
	dmem_rdata = dmem_re ? ram[dmem_addr[7:2]] : '0;
end

// a store lands mid-cycle, so a load in the next cycle sees it
always @(negedge clk) begin
	if (dmem_we && dmem_ready) begin
		ram[dmem_addr[7:2]] <= dmem_wdata;
	end
end

endmodule

`default_nettype wire

// ==== core_top.sv ====
// core top
// five-stage in-order pipeline: pc and IF/DEC register, decode with the
// register file, execute with forwarding muxes and ALU, memory stage on the
// data port, and the retire port driven from the MEM/WB register

`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module core_top (
	input wire clk,
	input wire rst_n,
	output logic [`CORE_XLEN-1:0] imem_addr,
	input wire [`CORE_XLEN-1:0] imem_data,
	input wire imem_valid,
	output logic [`CORE_XLEN-1:0] dmem_addr,
	output logic [`CORE_XLEN-1:0] dmem_wdata,
	output logic dmem_we,
	output logic dmem_re,
	input wire [`CORE_XLEN-1:0] dmem_rdata,
	input wire dmem_ready,
	output logic wb_valid,
	output logic wb_we,
	output logic [`CORE_REG_W-1:0] wb_rd,
	output logic [`CORE_XLEN-1:0] wb_data
);

logic [`CORE_ENB_W-1:0] enb_bus;
logic [`CORE_KILL_W-1:0] kill_bus;
logic redirect;
core_pkg::fwd_sel_t fwd_src1;
core_pkg::fwd_sel_t fwd_src2;
logic fwd_store;
logic stall_wb;

logic [`CORE_XLEN-1:0] pc;
logic [`CORE_XLEN-1:0] if_dec_pc;
logic [`CORE_XLEN-1:0] if_dec_instr;
logic if_dec_vld;

logic [`CORE_REG_W-1:0] dec_rs1;
logic [`CORE_REG_W-1:0] dec_rs2;
logic [`CORE_REG_W-1:0] dec_rd;
logic [`CORE_XLEN-1:0] dec_imm;
core_pkg::alu_op_t dec_alu_op;
logic dec_use_imm;
logic dec_we;
logic dec_mem_re;
logic dec_mem_we;
logic dec_brnch_ne;
logic dec_uses_rs1;
logic dec_uses_rs2;
core_pkg::hzrd_cmd_t dec_cmd;
logic [`CORE_XLEN-1:0] rf_rdata1;
logic [`CORE_XLEN-1:0] rf_rdata2;

core_pkg::dec_exe_t de_d;
core_pkg::dec_exe_t de_q;
core_pkg::exe_mem_t em_d;
core_pkg::exe_mem_t em_q;
core_pkg::mem_wb_t mw_d;
core_pkg::mem_wb_t mw_q;

logic [`CORE_XLEN-1:0] src1;
logic [`CORE_XLEN-1:0] src2;
logic [`CORE_XLEN-1:0] alu_b;
logic [`CORE_XLEN-1:0] alu_result;
logic [`CORE_XLEN-1:0] target;
logic brnch_tknn;
core_pkg::hzrd_cmd_t exe_cmd;

// ----------------------------------------------------------------------
// fetch
// ----------------------------------------------------------------------
always_ff @(posedge clk) begin
	if (!rst_n) begin
		pc <= `CORE_RESET_PC;
	end
	else if (redirect) begin
		pc <= target;
	end
	else if (enb_bus[`REG_IF_DEC]) begin
		pc <= pc + `CORE_XLEN'd4;
	end
end

assign imem_addr = pc;

// IF/DEC: pc and instruction word, plus its own valid
always_ff @(posedge clk) begin
	if (!rst_n) begin
		if_dec_vld <= 1'b0;
	end
	else if (kill_bus[`KILL_IF_DEC]) begin
		if_dec_vld <= 1'b0;
	end
	else if (enb_bus[`REG_IF_DEC]) begin
		if_dec_vld <= 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (enb_bus[`REG_IF_DEC]) begin
		{if_dec_pc, if_dec_instr} <= {pc, imem_data};
	end
end

// ----------------------------------------------------------------------
// decode
// ----------------------------------------------------------------------
core_decoder u_decoder (
	.instr(if_dec_instr),
	.rs1(dec_rs1),
	.rs2(dec_rs2),
	.rd(dec_rd),
	.imm(dec_imm),
	.alu_op(dec_alu_op),
	.use_imm(dec_use_imm),
	.we_reg(dec_we),
	.mem_re(dec_mem_re),
	.mem_we(dec_mem_we),
	.brnch_ne(dec_brnch_ne),
	.uses_rs1(dec_uses_rs1),
	.uses_rs2(dec_uses_rs2),
	.cmd(dec_cmd)
);

core_reg_file u_reg_file (
	.clk(clk),
	.we(mw_q.valid & mw_q.we),
	.waddr(mw_q.rd),
	.wdata(mw_q.wdata),
	.raddr1(dec_rs1),
	.raddr2(dec_rs2),
	.rdata1(rf_rdata1),
	.rdata2(rf_rdata2)
);

always_comb begin
	de_d.pc = if_dec_pc;
	de_d.rs1_val = rf_rdata1;
	de_d.rs2_val = rf_rdata2;
	de_d.imm = dec_imm;
	de_d.rs1 = dec_rs1;
	de_d.rs2 = dec_rs2;
	de_d.rd = dec_rd;
	de_d.we = dec_we;
	de_d.alu_op = dec_alu_op;
	de_d.use_imm = dec_use_imm;
	de_d.mem_re = dec_mem_re;
	de_d.mem_we = dec_mem_we;
	de_d.cmd = dec_cmd;
	de_d.brnch_ne = dec_brnch_ne;
	de_d.valid = if_dec_vld;
end

core_stage_reg #(.payload_t(core_pkg::dec_exe_t)) u_dec_exe (
	.clk(clk),
	.rst_n(rst_n),
	.enb(enb_bus[`REG_DEC_EXE]),
	.kill(kill_bus[`KILL_DEC_EXE]),
	.d(de_d),
	.q(de_q)
);

// ----------------------------------------------------------------------
// execute
// ----------------------------------------------------------------------
function automatic logic [`CORE_XLEN-1:0] fwd_pick(
	input core_pkg::fwd_sel_t sel,
	input logic [`CORE_XLEN-1:0] reg_val,
	input logic [`CORE_XLEN-1:0] mem_val,
	input logic [`CORE_XLEN-1:0] wb_val
);
	case (sel)
		core_pkg::fwd_mem: fwd_pick = mem_val;
		core_pkg::fwd_wb: fwd_pick = wb_val;
		default: fwd_pick = reg_val;
	endcase
endfunction

assign src1 = fwd_pick(fwd_src1, de_q.rs1_val, em_q.result, mw_q.wdata);
assign src2 = fwd_pick(fwd_src2, de_q.rs2_val, em_q.result, mw_q.wdata);

// jal links pc+4 through the ALU pass path
always_comb begin
	if (de_q.cmd == core_pkg::hzrd_jump) begin
		alu_b = de_q.pc + `CORE_XLEN'd4;
	end
	else if (de_q.use_imm) begin
		alu_b = de_q.imm;
	end
	else begin
		alu_b = src2;
	end
end

assign target = de_q.pc + de_q.imm;
assign exe_cmd = de_q.valid ? de_q.cmd : core_pkg::hzrd_none;

core_alu u_alu (
	.op(de_q.alu_op),
	.a(src1),
	.b(alu_b),
	.brnch_ne(de_q.brnch_ne),
	.result(alu_result),
	.brnch_tknn(brnch_tknn)
);

always_comb begin
	em_d.result = alu_result;
	em_d.store = src2;
	em_d.rs2 = de_q.rs2;
	em_d.rd = de_q.rd;
	em_d.we = de_q.we;
	em_d.mem_re = de_q.mem_re;
	em_d.mem_we = de_q.mem_we;
	em_d.cmd = de_q.cmd;
	em_d.valid = de_q.valid;
end

core_stage_reg #(.payload_t(core_pkg::exe_mem_t)) u_exe_mem (
	.clk(clk),
	.rst_n(rst_n),
	.enb(enb_bus[`REG_EXE_MEM]),
	.kill(1'b0),
	.d(em_d),
	.q(em_q)
);

// ----------------------------------------------------------------------
// memory and writeback
// ----------------------------------------------------------------------
assign dmem_addr = em_q.result;
assign dmem_wdata = fwd_store ? mw_q.wdata : em_q.store;
assign dmem_we = em_q.valid & em_q.mem_we;
assign dmem_re = em_q.valid & em_q.mem_re;
assign stall_wb = (dmem_we | dmem_re) & ~dmem_ready;

always_comb begin
	mw_d.wdata = (em_q.cmd == core_pkg::hzrd_load) ? dmem_rdata : em_q.result;
	mw_d.rd = em_q.rd;
	mw_d.we = em_q.we;
	mw_d.valid = em_q.valid;
end

core_stage_reg #(.payload_t(core_pkg::mem_wb_t)) u_mem_wb (
	.clk(clk),
	.rst_n(rst_n),
	.enb(enb_bus[`REG_MEM_WB]),
	.kill(1'b0),
	.d(mw_d),
	.q(mw_q)
);

// retire on the cycle the slot moves on, so a frozen slot counts once
assign wb_valid = mw_q.valid & enb_bus[`REG_MEM_WB];
assign wb_we = mw_q.valid & mw_q.we;
assign wb_rd = mw_q.rd;
assign wb_data = mw_q.wdata;

core_hazard_ctrl u_hazard_ctrl (
	.rst_n(rst_n),
	.dec_rs1(dec_rs1),
	.dec_rs2(dec_rs2),
	.dec_uses_rs1(dec_uses_rs1 & if_dec_vld),
	.dec_uses_rs2(dec_uses_rs2 & if_dec_vld),
	.exe_rs1(de_q.rs1),
	.exe_rs2(de_q.rs2),
	.exe_rd(de_q.rd),
	.exe_we(de_q.valid & de_q.we),
	.exe_cmd(exe_cmd),
	.mem_rs2(em_q.rs2),
	.mem_rd(em_q.rd),
	.mem_we(em_q.valid & em_q.we),
	.wb_rd(mw_q.rd),
	.wb_we(mw_q.valid & mw_q.we),
	.brnch_tknn(brnch_tknn),
	.stall_dec(~imem_valid),
	.stall_wb(stall_wb),
	.enb_bus(enb_bus),
	.kill_bus(kill_bus),
	.redirect(redirect),
	.fwd_src1(fwd_src1),
	.fwd_src2(fwd_src2),
	.fwd_store(fwd_store)
);

endmodule

`default_nettype wire

// ==== core_hazard_ctrl.sv ====
// core hazard controller
// per-stage register enables and kills, forwarding selects for execute and
// for store data in mem, and the fetch redirect select. write enables come
// in already qualified by the stage valid bits

`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module core_hazard_ctrl (
	input wire rst_n,
	// decode stage
	input wire [`CORE_REG_W-1:0] dec_rs1,
	input wire [`CORE_REG_W-1:0] dec_rs2,
	input wire dec_uses_rs1,
	input wire dec_uses_rs2,
	// execute stage
	input wire [`CORE_REG_W-1:0] exe_rs1,
	input wire [`CORE_REG_W-1:0] exe_rs2,
	input wire [`CORE_REG_W-1:0] exe_rd,
	input wire exe_we,
	input wire core_pkg::hzrd_cmd_t exe_cmd,
	// memory stage
	input wire [`CORE_REG_W-1:0] mem_rs2,
	input wire [`CORE_REG_W-1:0] mem_rd,
	input wire mem_we,
	// writeback stage
	input wire [`CORE_REG_W-1:0] wb_rd,
	input wire wb_we,
	input wire brnch_tknn,
	input wire stall_dec,
	input wire stall_wb,
	output logic [`CORE_ENB_W-1:0] enb_bus,
	output logic [`CORE_KILL_W-1:0] kill_bus,
	output logic redirect,
	output core_pkg::fwd_sel_t fwd_src1,
	output core_pkg::fwd_sel_t fwd_src2,
	output logic fwd_store
);

logic load_use;
logic taken;

// ----------------------------------------------------------------------
// forwarding
// ----------------------------------------------------------------------

// mem beats wb, each source on its own
function automatic core_pkg::fwd_sel_t pick_src(input logic [`CORE_REG_W-1:0] rs);
	if (rs != '0 && mem_we && mem_rd == rs) begin
		pick_src = core_pkg::fwd_mem;
	end
	else if (rs != '0 && wb_we && wb_rd == rs) begin
		pick_src = core_pkg::fwd_wb;
	end
	else begin
		pick_src = core_pkg::fwd_regfile;
	end
endfunction

always_comb begin
	fwd_src1 = core_pkg::fwd_regfile;
	fwd_src2 = core_pkg::fwd_regfile;
	fwd_store = 1'b0;
	if (rst_n) begin
		fwd_src1 = pick_src(exe_rs1);
		fwd_src2 = pick_src(exe_rs2);
		// covers a store right behind the load of its data
		fwd_store = (mem_rs2 != '0) && wb_we && (wb_rd == mem_rs2);
	end
end

// ----------------------------------------------------------------------
// stalls, bubbles and redirect
// ----------------------------------------------------------------------
assign load_use = (exe_cmd == core_pkg::hzrd_load) && exe_we && (exe_rd != '0) &&
	((dec_uses_rs1 && dec_rs1 == exe_rd) || (dec_uses_rs2 && dec_rs2 == exe_rd));

assign taken = (exe_cmd == core_pkg::hzrd_jump) ||
	((exe_cmd == core_pkg::hzrd_brnch) && brnch_tknn);

always_comb begin
	enb_bus = '1;
	kill_bus = '0;
	redirect = 1'b0;
	if (!rst_n) begin
		kill_bus = '1;
	end
	else begin
		// jal or taken branch, squash both younger slots
		if (taken) begin
			redirect = 1'b1;
			kill_bus[`KILL_IF_DEC] = 1'b1;
			kill_bus[`KILL_DEC_EXE] = 1'b1;
		end
		// hold decode, bubble into execute
		if (load_use || stall_dec) begin
			enb_bus[`REG_IF_DEC] = 1'b0;
			kill_bus[`KILL_DEC_EXE] = 1'b1;
		end
		// data port not ready, freeze the whole pipe
		if (stall_wb) begin
			enb_bus = '0;
			kill_bus = '0;
			redirect = 1'b0;
		end
	end
end

endmodule

`default_nettype wire

// ==== core_decoder.sv ====
// core decoder
// splits an RV32I word of the supported subset into register indices, the
// immediate, datapath controls and the command for the hazard controller.
// anything outside the subset decodes as a no-op

`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module core_decoder (
	input wire [`CORE_XLEN-1:0] instr,
	output logic [`CORE_REG_W-1:0] rs1,
	output logic [`CORE_REG_W-1:0] rs2,
	output logic [`CORE_REG_W-1:0] rd,
	output logic [`CORE_XLEN-1:0] imm,
	output core_pkg::alu_op_t alu_op,
	output logic use_imm,
	output logic we_reg,
	output logic mem_re,
	output logic mem_we,
	output logic brnch_ne,
	output logic uses_rs1,
	output logic uses_rs2,
	output core_pkg::hzrd_cmd_t cmd
);

localparam logic [6:0] op_reg = 7'b0110011;
localparam logic [6:0] op_imm = 7'b0010011;
localparam logic [6:0] op_load = 7'b0000011;
localparam logic [6:0] op_store = 7'b0100011;
localparam logic [6:0] op_branch = 7'b1100011;
localparam logic [6:0] op_jal = 7'b1101111;

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;

assign opcode = instr[6:0];
assign funct3 = instr[14:12];
assign funct7 = instr[31:25];
assign rs1 = instr[19:15];
assign rs2 = instr[24:20];
assign rd = instr[11:7];
assign brnch_ne = funct3[0];

always_comb begin
	alu_op = core_pkg::alu_add;
	cmd = core_pkg::hzrd_none;
	use_imm = 1'b0;
	we_reg = 1'b0;
	mem_re = 1'b0;
	mem_we = 1'b0;
	uses_rs1 = 1'b0;
	uses_rs2 = 1'b0;
	// I-type by default
	imm = {{20{instr[31]}}, instr[31:20]};
	case (opcode)
		op_reg: begin
			if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
				alu_op = funct7[5] ? core_pkg::alu_sub : core_pkg::alu_add;
				we_reg = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
		end
		op_imm: begin
			if (funct3 == 3'b000) begin
				use_imm = 1'b1;
				we_reg = 1'b1;
				uses_rs1 = 1'b1;
			end
		end
		op_load: begin
			if (funct3 == 3'b010) begin
				use_imm = 1'b1;
				we_reg = 1'b1;
				mem_re = 1'b1;
				uses_rs1 = 1'b1;
				cmd = core_pkg::hzrd_load;
			end
		end
		// store data is patched in the mem stage, so rs2 is not a decode source
		op_store: begin
			if (funct3 == 3'b010) begin
				use_imm = 1'b1;
				mem_we = 1'b1;
				uses_rs1 = 1'b1;
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
		end
		op_branch: begin
			if (funct3[2:1] == 2'b00) begin
				alu_op = core_pkg::alu_cmp;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				cmd = core_pkg::hzrd_brnch;
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
		end
		op_jal: begin
			alu_op = core_pkg::alu_pass_b;
			we_reg = 1'b1;
			cmd = core_pkg::hzrd_jump;
			imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
		end
		default: begin
		end
	endcase
end

endmodule

`default_nettype wire

// ==== core_alu.sv ====
// core ALU
// add, subtract and pass of the second operand, plus the equality compare
// that resolves beq and bne in execute

`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module core_alu (
	input wire core_pkg::alu_op_t op,
	input wire [`CORE_XLEN-1:0] a,
	input wire [`CORE_XLEN-1:0] b,
	input wire brnch_ne,
	output logic [`CORE_XLEN-1:0] result,
	output logic brnch_tknn
);

logic [`CORE_XLEN-1:0] diff;

// one subtractor serves sub and the compare
assign diff = a - b;

always_comb begin
	case (op)
		core_pkg::alu_add: result = a + b;
		core_pkg::alu_sub: result = diff;
		core_pkg::alu_pass_b: result = b;
		default: result = diff;
	endcase
end

// taken when equality matches the branch sense
assign brnch_tknn = (op == core_pkg::alu_cmp) && ((diff == '0) != brnch_ne);

endmodule

`default_nettype wire

// ==== core_reg_file.sv ====
// core register file
// 31 writable 32-bit registers, x0 reads as zero. a read of the register
// being written returns the new value

`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module core_reg_file (
	input wire clk,
	input wire we,
	input wire [`CORE_REG_W-1:0] waddr,
	input wire [`CORE_XLEN-1:0] wdata,
	input wire [`CORE_REG_W-1:0] raddr1,
	input wire [`CORE_REG_W-1:0] raddr2,
	output logic [`CORE_XLEN-1:0] rdata1,
	output logic [`CORE_XLEN-1:0] rdata2
);

logic [`CORE_XLEN-1:0] regs [1:(1 << `CORE_REG_W)-1];

always_ff @(posedge clk) begin
	if (we && waddr != '0) begin
		regs[waddr] <= wdata;
	end
end

// write-through so writeback to decode needs no bypass
function automatic logic [`CORE_XLEN-1:0] rd_port(input logic [`CORE_REG_W-1:0] addr);
	if (addr == '0) begin
		rd_port = '0;
	end
	else if (we && waddr == addr) begin
		rd_port = wdata;
	end
	else begin
		rd_port = regs[addr];
	end
endfunction

always_comb begin
	rdata1 = rd_port(raddr1);
	rdata2 = rd_port(raddr2);
end

endmodule

`default_nettype wire

// ==== core_stage_reg.sv ====
// core stage register
// one pipeline register between two stages. holds on enable low, turns the
// slot into a bubble on kill or reset by clearing the valid field

`timescale 1ns/1ns
`default_nettype none

module core_stage_reg #(
	parameter type payload_t = core_pkg::mem_wb_t
) (
	input wire clk,
	input wire rst_n,
	input wire enb,
	input wire kill,
	input wire payload_t d,
	output payload_t q
);

// kill wins over enable, the rest of the payload is left as it was
always_ff @(posedge clk) begin
	if (!rst_n) begin
		q.valid <= 1'b0;
	end
	else if (kill) begin
		q.valid <= 1'b0;
	end
	else if (enb) begin
		q <= d;
	end
end

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
// core package
// hazard command, ALU operation and forwarding select encodings, plus the
// payload structs carried by the pipeline stage registers

`default_nettype none

`include "core_macros.svh"

package core_pkg;

// what a stage holds, as seen by the hazard controller
typedef enum logic [1:0] {
	hzrd_none = 2'd0,
	hzrd_jump = 2'd1,
	hzrd_brnch = 2'd2,
	hzrd_load = 2'd3
} hzrd_cmd_t;

typedef enum logic [1:0] {
	alu_add = 2'd0,
	alu_sub = 2'd1,
	alu_pass_b = 2'd2,
	alu_cmp = 2'd3
} alu_op_t;

// source of one execute operand
typedef enum logic [1:0] {
	fwd_regfile = 2'd0,
	fwd_mem = 2'd1,
	fwd_wb = 2'd2
} fwd_sel_t;

// ----------------------------------------------------------------------
// stage payloads
// ----------------------------------------------------------------------
typedef struct packed {
	logic [`CORE_XLEN-1:0] pc;
	logic [`CORE_XLEN-1:0] rs1_val;
	logic [`CORE_XLEN-1:0] rs2_val;
	logic [`CORE_XLEN-1:0] imm;
	logic [`CORE_REG_W-1:0] rs1;
	logic [`CORE_REG_W-1:0] rs2;
	logic [`CORE_REG_W-1:0] rd;
	logic we;
	alu_op_t alu_op;
	logic use_imm;
	logic mem_re;
	logic mem_we;
	hzrd_cmd_t cmd;
	logic brnch_ne;
	logic valid;
} dec_exe_t;

typedef struct packed {
	logic [`CORE_XLEN-1:0] result;
	logic [`CORE_XLEN-1:0] store;
	logic [`CORE_REG_W-1:0] rs2;
	logic [`CORE_REG_W-1:0] rd;
	logic we;
	logic mem_re;
	logic mem_we;
	hzrd_cmd_t cmd;
	logic valid;
} exe_mem_t;

typedef struct packed {
	logic [`CORE_XLEN-1:0] wdata;
	logic [`CORE_REG_W-1:0] rd;
	logic we;
	logic valid;
} mem_wb_t;

endpackage

`default_nettype wire

// ==== core_macros.svh ====
// core macros
// shared widths, stage-register bus positions and the reset fetch address
// for the five-stage integer pipeline

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and register index widths
`define CORE_XLEN 32
`define CORE_REG_W 5

// ----------------------------------------------------------------------
// stage register control buses
// ----------------------------------------------------------------------
`define CORE_ENB_W 4
`define CORE_KILL_W 2

// enable bus, one bit per stage register
`define REG_IF_DEC 0
`define REG_DEC_EXE 1
`define REG_EXE_MEM 2
`define REG_MEM_WB 3

// kill bus, only the two front registers can be squashed
`define KILL_IF_DEC 0
`define KILL_DEC_EXE 1

// first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

`endif
